// File: Makefile
TOP := tb_nco

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f nco.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Test passed" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f nco.f

clean:
	rm -rf obj_dir sim.log

// File: nco.f
+incdir+.
nco_pkg.sv
nco_phase_acc.sv
nco_cordic.sv
nco_quadrant_track.sv
nco_quadrant_map.sv
nco_top.sv
nco_chk.sv
tb_nco.sv

// File: nco_chk.sv
`timescale 1ns/100ps

module nco_chk (
  input logic             clk,
  input logic             rst_n_i,
  input logic             clken_i,
  input nco_pkg::sample_t fsin_i,
  input nco_pkg::sample_t fcos_i,
  input logic             data_ready_i
);

  // the fill counter starts over on every reset
  a_ready_low_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !data_ready_i)
    else $error("data_ready_o was high in the first cycle after reset");

  a_ready_sticky: assert property (@(posedge clk) disable iff (!rst_n_i) !$fell(data_ready_i))
    else $error("data_ready_o fell while out of reset");

  // a low clock enable freezes the output registers
  a_hold_when_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
    !clken_i |=> ($stable(fsin_i) && $stable(fcos_i)))
    else $error("fsin_o or fcos_o changed while clken_i was low");

endmodule

bind nco_top nco_chk i_nco_chk (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .clken_i      (clken_i),
  .fsin_i       (fsin_o),
  .fcos_i       (fcos_o),
  .data_ready_i (data_ready_o)
);

// File: nco_consts.svh
`ifndef NCO_CONSTS_SVH
`define NCO_CONSTS_SVH

`define NCO_PHASE_W 32
`define NCO_OUT_W 16

// CORDIC angle register, 2^16 is half a turn
`define NCO_ZW 18
`define NCO_RES_W 15
`define NCO_STAGES 16

// full scale divided by the CORDIC gain of about 1.6468
`define NCO_X0 19897

// arctangent of 2^-i with 90 degrees at 32768
`define NCO_ATAN_0 16384
`define NCO_ATAN_1 9672
`define NCO_ATAN_2 5110
`define NCO_ATAN_3 2594
`define NCO_ATAN_4 1302
`define NCO_ATAN_5 652
`define NCO_ATAN_6 326
`define NCO_ATAN_7 163
`define NCO_ATAN_8 81
`define NCO_ATAN_9 41
`define NCO_ATAN_10 20
`define NCO_ATAN_11 10
`define NCO_ATAN_12 5
`define NCO_ATAN_13 3
`define NCO_ATAN_14 1

`define NCO_LATENCY 19

`endif

// File: nco_cordic.sv
`timescale 1ns/100ps
`include "nco_consts.svh"

module nco_cordic (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    clken_i,
  input  logic [`NCO_RES_W-1:0]   residual_i,
  output nco_pkg::sample_t        mag_cos_o,
  output nco_pkg::sample_t        mag_sin_o
);

  // x and y carry two guard bits below the output LSB and one bit of headroom
  localparam int GUARD = 2;
  localparam int XY_W  = `NCO_OUT_W + 2 + GUARD;

  localparam logic signed [XY_W-1:0] X_INIT   = `NCO_X0 <<< GUARD;
  localparam logic signed [XY_W-1:0] HALF_LSB = 1 <<< (GUARD - 1);
  localparam logic signed [XY_W-1:0] SAT_HI   = (2 ** (`NCO_OUT_W - 1)) - 1;

  logic signed [XY_W-1:0] x_q [0:`NCO_STAGES];
  logic signed [XY_W-1:0] y_q [0:`NCO_STAGES];
  nco_pkg::angle_t        z_q [0:`NCO_STAGES-1];

  function automatic nco_pkg::angle_t atan_of(input int stage);
    case (stage)
      0:       atan_of = `NCO_ATAN_0;
      1:       atan_of = `NCO_ATAN_1;
      2:       atan_of = `NCO_ATAN_2;
      3:       atan_of = `NCO_ATAN_3;
      4:       atan_of = `NCO_ATAN_4;
      5:       atan_of = `NCO_ATAN_5;
      6:       atan_of = `NCO_ATAN_6;
      7:       atan_of = `NCO_ATAN_7;
      8:       atan_of = `NCO_ATAN_8;
      9:       atan_of = `NCO_ATAN_9;
      10:      atan_of = `NCO_ATAN_10;
      11:      atan_of = `NCO_ATAN_11;
      12:      atan_of = `NCO_ATAN_12;
      13:      atan_of = `NCO_ATAN_13;
      14:      atan_of = `NCO_ATAN_14;
      default: atan_of = '0;
    endcase
  endfunction

  // round away the guard bits and clamp so that the mapper can negate safely
  function automatic nco_pkg::sample_t to_sample(input logic signed [XY_W-1:0] v);
    logic signed [XY_W-1:0] r;
    r = (v + HALF_LSB) >>> GUARD;
    if (r > SAT_HI) begin
      r = SAT_HI;
    end else if (r < -SAT_HI) begin
      r = -SAT_HI;
    end
    to_sample = r[`NCO_OUT_W-1:0];
  endfunction

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      x_q[0] <= '0;
      y_q[0] <= '0;
      z_q[0] <= '0;
    end else if (clken_i) begin
      x_q[0] <= X_INIT;
      y_q[0] <= '0;
      z_q[0] <= {{(`NCO_ZW - `NCO_RES_W){1'b0}}, residual_i};
    end
  end

  for (genvar i = 0; i < `NCO_STAGES; i++) begin : g_stage
    // z >= 0 still has angle left to turn, so rotate counter-clockwise
    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        x_q[i+1] <= '0;
        y_q[i+1] <= '0;
      end else if (clken_i) begin
        if (!z_q[i][`NCO_ZW-1]) begin
          x_q[i+1] <= x_q[i] - (y_q[i] >>> i);
          y_q[i+1] <= y_q[i] + (x_q[i] >>> i);
        end else begin
          x_q[i+1] <= x_q[i] + (y_q[i] >>> i);
          y_q[i+1] <= y_q[i] - (x_q[i] >>> i);
        end
      end
    end

    // the last stage only needs the sign of z, its update is never read
    if (i < `NCO_STAGES - 1) begin : g_angle
      always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
          z_q[i+1] <= '0;
        end else if (clken_i) begin
          z_q[i+1] <= z_q[i][`NCO_ZW-1] ? z_q[i] + atan_of(i) : z_q[i] - atan_of(i);
        end
      end
    end
  end

  assign mag_cos_o = to_sample(x_q[`NCO_STAGES]);
  assign mag_sin_o = to_sample(y_q[`NCO_STAGES]);

endmodule

// File: nco_phase_acc.sv
`timescale 1ns/100ps
`include "nco_consts.svh"

module nco_phase_acc (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      clken_i,
  input  logic [`NCO_PHASE_W-1:0]   phi_inc_i,
  output nco_pkg::phase_word_u      phase_o
);

  nco_pkg::phase_word_u acc_q;

  // wraps modulo 2^32, one full turn per overflow
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q.raw <= '0;
    end else if (clken_i) begin
      acc_q.raw <= acc_q.raw + phi_inc_i;
    end
  end

  assign phase_o.fields = acc_q.fields;

endmodule

// File: nco_pkg.sv
`include "nco_consts.svh"

package nco_pkg;

  // top two bits pick the quadrant, the rest is the angle inside it
  typedef struct packed {
    logic [1:0]                quadrant;
    logic [`NCO_PHASE_W-3:0]   residual;
  } phase_fields_t;

  // the accumulator word, summed as a number and split as fields
  typedef union packed {
    logic [`NCO_PHASE_W-1:0]   raw;
    phase_fields_t             fields;
  } phase_word_u;

  typedef logic signed [`NCO_OUT_W-1:0] sample_t;

  typedef logic signed [`NCO_ZW-1:0] angle_t;

endpackage

// File: nco_quadrant_map.sv
`timescale 1ns/100ps

module nco_quadrant_map (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               clken_i,
  input  logic [1:0]         quad_i,
  input  nco_pkg::sample_t   mag_cos_i,
  input  nco_pkg::sample_t   mag_sin_i,
  output nco_pkg::sample_t   fsin_o,
  output nco_pkg::sample_t   fcos_o
);

  nco_pkg::sample_t sin_d;
  nco_pkg::sample_t cos_d;

  // each quadrant adds a quarter turn, which swaps and negates the pair
  always_comb begin
    case (quad_i)
      2'd0: begin
        sin_d = mag_sin_i;
        cos_d = mag_cos_i;
      end
      2'd1: begin
        sin_d = mag_cos_i;
        cos_d = -mag_sin_i;
      end
      2'd2: begin
        sin_d = -mag_sin_i;
        cos_d = -mag_cos_i;
      end
      default: begin
        sin_d = -mag_cos_i;
        cos_d = mag_sin_i;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fsin_o <= '0;
      fcos_o <= '0;
    end else if (clken_i) begin
      fsin_o <= sin_d;
      fcos_o <= cos_d;
    end
  end

endmodule

// File: nco_quadrant_track.sv
`timescale 1ns/100ps
`include "nco_consts.svh"

module nco_quadrant_track (
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         clken_i,
  input  logic [1:0]   quadrant_i,
  output logic [1:0]   quad_o,
  output logic         data_ready_o
);

  // same depth as the CORDIC, its load stage plus one per rotation
  localparam int DEPTH = `NCO_STAGES + 1;
  localparam int CNT_W = $clog2(`NCO_LATENCY + 1);

  logic [2*DEPTH-1:0] quad_sr;
  logic [CNT_W-1:0]   fill_cnt;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      quad_sr <= '0;
    end else if (clken_i) begin
      quad_sr <= {quad_sr[2*DEPTH-3:0], quadrant_i};
    end
  end

  assign quad_o = quad_sr[2*DEPTH-1 -: 2];

  // counts enabled cycles once after reset and then sticks at the latency
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fill_cnt <= '0;
    end else if (clken_i && (fill_cnt != CNT_W'(`NCO_LATENCY))) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  assign data_ready_o = (fill_cnt == CNT_W'(`NCO_LATENCY));

endmodule

// File: nco_top.sv
`timescale 1ns/100ps
`include "nco_consts.svh"

module nco_top (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      clken_i,
  input  logic [`NCO_PHASE_W-1:0]   phi_inc_i,
  output nco_pkg::sample_t          fsin_o,
  output nco_pkg::sample_t          fcos_o,
  output logic                      data_ready_o
);

  nco_pkg::phase_word_u phase;
  nco_pkg::sample_t     mag_cos;
  nco_pkg::sample_t     mag_sin;
  logic [1:0]           quad_d;

  nco_phase_acc i_nco_phase_acc (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .clken_i    (clken_i),
    .phi_inc_i  (phi_inc_i),
    .phase_o    (phase)
  );

  // only the upper residual bits reach the CORDIC
  nco_cordic i_nco_cordic (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .clken_i    (clken_i),
    .residual_i (phase.fields.residual[`NCO_PHASE_W-3 -: `NCO_RES_W]),
    .mag_cos_o  (mag_cos),
    .mag_sin_o  (mag_sin)
  );

  nco_quadrant_track i_nco_quadrant_track (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .clken_i      (clken_i),
    .quadrant_i   (phase.fields.quadrant),
    .quad_o       (quad_d),
    .data_ready_o (data_ready_o)
  );

  nco_quadrant_map i_nco_quadrant_map (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .clken_i    (clken_i),
    .quad_i     (quad_d),
    .mag_cos_i  (mag_cos),
    .mag_sin_i  (mag_sin),
    .fsin_o     (fsin_o),
    .fcos_o     (fcos_o)
  );

endmodule

// File: tb_nco.sv
`timescale 1ns/100ps
`include "nco_consts.svh"

module tb_nco;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 10;
  localparam int ZERO_CYCLES    = 60;
  localparam int SWEEP_CYCLES   = 400;
  localparam int STALL_CYCLES   = 25;
  localparam int RESUME_CYCLES  = 200;
  localparam int RANDOM_CYCLES  = 300;
  localparam int SHORT_STALL    = 15;
  localparam int GAPPY_CYCLES   = 150;
  localparam int DRAIN_CYCLES   = 30;
  localparam int TEST_CYCLES    = RESET_CYCLES + ZERO_CYCLES + SWEEP_CYCLES + STALL_CYCLES
                                  + RESUME_CYCLES + RANDOM_CYCLES + SHORT_STALL
                                  + GAPPY_CYCLES + DRAIN_CYCLES;
  localparam int TOL            = 4;
  localparam real PI            = 3.14159265358979;
  // one full turn every 97 samples
  localparam logic [31:0] SWEEP_INC = 32'(64'd4294967296 / 97);

  logic                     clk;
  logic                     rst_n_i;
  logic                     clken_i;
  logic [`NCO_PHASE_W-1:0]  phi_inc_i;
  nco_pkg::sample_t         fsin_o;
  nco_pkg::sample_t         fcos_o;
  logic                     data_ready_o;

  // the model queues one phase per enabled cycle still inside the pipeline
  logic [31:0]      phase_q [$];
  logic [31:0]      acc_m;
  int               en_done;
  logic             was_stalled;
  nco_pkg::sample_t last_sin;
  nco_pkg::sample_t last_cos;

  int err_reset;
  int err_ready;
  int err_value;
  int err_stall;
  int err_other;
  int n_compared;

  nco_top i_nco_top (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .clken_i      (clken_i),
    .phi_inc_i    (phi_inc_i),
    .fsin_o       (fsin_o),
    .fcos_o       (fcos_o),
    .data_ready_o (data_ready_o)
  );

  function automatic void sin_cos_ref(input logic [31:0] phase, output int exp_sin,
                                      output int exp_cos);
    real angle;
    angle = 2.0 * PI * (real'(phase) / 4294967296.0);
    exp_sin = int'(32767.0 * $sin(angle));
    exp_cos = int'(32767.0 * $cos(angle));
  endfunction

  function automatic bit within_tol(input int got, input int want);
    return (got - want <= TOL) && (want - got <= TOL);
  endfunction

  task automatic check_reset_state();
    assert (fsin_o == '0 && fcos_o == '0 && !data_ready_o) else begin
      err_reset++;
      $display("[ERROR] %0t: after reset fsin_o %0d fcos_o %0d data_ready_o %0b",
               $time, fsin_o, fcos_o, data_ready_o);
    end
  endtask

  task automatic run_fixed(input logic [31:0] inc, input int cycles, input int en_pct);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      phi_inc_i = inc;
      clken_i = (int'($urandom_range(99)) < en_pct);
    end
  endtask

  // a new random increment every one to eight cycles
  task automatic run_random(input int cycles, input int en_pct);
    int hold;
    hold = 0;
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (hold == 0) begin
        phi_inc_i = $urandom();
        hold = int'($urandom_range(8, 1));
      end
      hold--;
      clken_i = (int'($urandom_range(99)) < en_pct);
    end
  endtask

  task automatic stall(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      clken_i = 1'b0;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : compare
    int          got_sin;
    int          got_cos;
    int          exp_sin;
    int          exp_cos;
    logic [31:0] exp_phase;
    forever begin
      @(posedge clk);
      if (!rst_n_i) begin
        acc_m = '0;
        en_done = 0;
        was_stalled = 1'b0;
        phase_q.delete();
      end else begin
        assert (data_ready_o == (en_done >= `NCO_LATENCY)) else begin
          err_ready++;
          $display("[ERROR] %0t: data_ready_o is %0b after %0d enabled cycles",
                   $time, data_ready_o, en_done);
        end
        if (was_stalled) begin
          assert (fsin_o == last_sin && fcos_o == last_cos) else begin
            err_stall++;
            $display("[ERROR] %0t: outputs moved during a stall, sin %0d -> %0d cos %0d -> %0d",
                     $time, last_sin, fsin_o, last_cos, fcos_o);
          end
        end
        if (clken_i) begin
          // the oldest queued phase is the one now standing at the outputs
          if (phase_q.size() == `NCO_LATENCY - 1) begin
            exp_phase = phase_q.pop_front();
            if (data_ready_o) begin
              sin_cos_ref(exp_phase, exp_sin, exp_cos);
              got_sin = int'(fsin_o);
              got_cos = int'(fcos_o);
              n_compared++;
              assert (within_tol(got_sin, exp_sin) && within_tol(got_cos, exp_cos)) else begin
                err_value++;
                $display("[ERROR] %0t: phase %08h gave sin %0d cos %0d, expected %0d %0d",
                         $time, exp_phase, got_sin, got_cos, exp_sin, exp_cos);
              end
            end
          end
          phase_q.push_back(acc_m);
          acc_m = acc_m + phi_inc_i;
          en_done++;
        end
        was_stalled = !clken_i;
        last_sin = fsin_o;
        last_cos = fcos_o;
      end
    end
  end

  initial begin : watchdog
    #((TEST_CYCLES + 200) * CLK_PERIOD);
    $display("timeout: the stimulus did not finish within %0d clock cycles",
             TEST_CYCLES + 200);
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    rst_n_i = 1'b0;
    clken_i = 1'b0;
    phi_inc_i = '0;
    err_reset = 0;
    err_ready = 0;
    err_value = 0;
    err_stall = 0;
    err_other = 0;
    n_compared = 0;
    void'($urandom(15055));
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    check_reset_state();
    // zero increment while the pipeline fills through random gaps
    run_fixed(32'd0, ZERO_CYCLES, 70);
    run_fixed(SWEEP_INC, SWEEP_CYCLES, 100);
    stall(STALL_CYCLES);
    run_fixed(SWEEP_INC, RESUME_CYCLES, 90);
    run_random(RANDOM_CYCLES, 80);
    stall(SHORT_STALL);
    run_random(GAPPY_CYCLES, 60);
    run_fixed(32'd0, DRAIN_CYCLES, 100);
    @(negedge clk);
    assert (n_compared >= SWEEP_CYCLES) else begin
      err_other++;
      $display("too few output samples were compared: %0d", n_compared);
    end
    $display("errors: reset %0d, ready %0d, value %0d, stall %0d, other %0d (%0d compared)",
             err_reset, err_ready, err_value, err_stall, err_other, n_compared);
    if (err_reset + err_ready + err_value + err_stall + err_other == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
